// File: axi_bus_pkg.sv
package axi_bus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Channel payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Write address
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_aw_t;

    // Write data beat
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } axi_w_t;

    // Write response
    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Arbiter phases
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ADDR,
        ARB_DATA,
        ARB_RESP
    } arb_state_t;

endpackage

// File: axi_master_mux_aw.sv
`timescale 1ns/1ps

module axi_master_mux_aw
    import axi_bus_pkg::*;
#(
    parameter int NUM_MASTERS = 3
) (
    input  logic    [NUM_MASTERS-1:0] grant,
    input  axi_aw_t [NUM_MASTERS-1:0] m_aw,
    input  logic    [NUM_MASTERS-1:0] m_awvalid,
    output logic    [NUM_MASTERS-1:0] m_awready,
    output axi_aw_t                   s_aw,
    output logic                      s_awvalid,
    input  logic                      s_awready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Master to slave
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        s_aw      = '0;
        s_awvalid = 1'b0;
        if ($onehot(grant)) begin
            for (int i = 0; i < NUM_MASTERS; i++) begin
                if (grant[i]) begin
                    s_aw      = m_aw[i];
                    s_awvalid = m_awvalid[i];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Ready back to the owner
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        m_awready = '0;
        if ($onehot(grant)) begin
            for (int i = 0; i < NUM_MASTERS; i++) begin
                m_awready[i] = grant[i] & s_awready;
            end
        end
    end

endmodule

// File: axi_master_mux_w.sv
`timescale 1ns/1ps

module axi_master_mux_w
    import axi_bus_pkg::*;
#(
    parameter int NUM_MASTERS = 3
) (
    input  logic   [NUM_MASTERS-1:0] grant,
    input  axi_w_t [NUM_MASTERS-1:0] m_w,
    input  logic   [NUM_MASTERS-1:0] m_wvalid,
    output logic   [NUM_MASTERS-1:0] m_wready,
    output axi_w_t                   s_w,
    output logic                     s_wvalid,
    input  logic                     s_wready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data beat select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Beats only pass for a single owner
    always_comb begin
        s_w      = '0;
        s_wvalid = 1'b0;
        if ($onehot(grant)) begin
            for (int i = 0; i < NUM_MASTERS; i++) begin
                if (grant[i]) begin
                    s_w      = m_w[i];
                    s_wvalid = m_wvalid[i];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wready routing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        m_wready = '0;
        if ($onehot(grant)) begin
            for (int i = 0; i < NUM_MASTERS; i++) begin
                m_wready[i] = grant[i] & s_wready;
            end
        end
    end

    // No data toward the slave without an owner
    always_comb begin
        if (s_wvalid) begin
            wvalid_needs_grant: assert (grant != '0);
        end
    end

endmodule

// File: axi_slave_demux_b.sv
`timescale 1ns/1ps

module axi_slave_demux_b
    import axi_bus_pkg::*;
#(
    parameter int NUM_MASTERS = 3
) (
    input  logic   [NUM_MASTERS-1:0] grant,
    input  axi_b_t                   s_b,
    input  logic                     s_bvalid,
    output logic                     s_bready,
    output axi_b_t [NUM_MASTERS-1:0] m_b,
    output logic   [NUM_MASTERS-1:0] m_bvalid,
    input  logic   [NUM_MASTERS-1:0] m_bready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response fan-out
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Payload goes everywhere, valid only to the owner
    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            m_b[i]      = s_b;
            m_bvalid[i] = grant[i] & s_bvalid;
        end
    end

    // Back-pressure comes from the owner alone
    always_comb begin
        s_bready = 1'b0;
        if ($onehot(grant)) begin
            s_bready = |(grant & m_bready);
        end
    end

endmodule

// File: axi_write_arbiter.sv
`timescale 1ns/1ps

module axi_write_arbiter
    import axi_bus_pkg::*;
#(
    parameter int NUM_MASTERS = 3
) (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic [NUM_MASTERS-1:0] m_awvalid,
    input  logic                   s_awvalid,
    input  logic                   s_awready,
    input  logic                   s_wvalid,
    input  logic                   s_wready,
    input  axi_w_t                 s_w,
    input  logic                   s_bvalid,
    input  logic                   s_bready,
    output logic [NUM_MASTERS-1:0] grant
);

    localparam int IDX_WIDTH = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

    arb_state_t             state;
    logic [IDX_WIDTH-1:0]   last_idx;
    logic [IDX_WIDTH-1:0]   pick_idx;
    logic                   pick_valid;
    logic                   aw_fire;
    logic                   w_last_fire;
    logic                   b_fire;

    assign aw_fire     = s_awvalid && s_awready;
    assign w_last_fire = s_wvalid && s_wready && s_w.last;
    assign b_fire      = s_bvalid && s_bready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin pick
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Search starts one past the last winner
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int i = 1; i <= NUM_MASTERS; i++) begin
            cand = (int'(last_idx) + i) % NUM_MASTERS;
            if (!pick_valid && m_awvalid[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = IDX_WIDTH'(cand);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transaction phases
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ARB_IDLE;
            grant    <= '0;
            // Master 0 goes first after reset
            last_idx <= IDX_WIDTH'(NUM_MASTERS - 1);
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_valid) begin
                        grant    <= NUM_MASTERS'(1) << pick_idx;
                        last_idx <= pick_idx;
                        state    <= ARB_ADDR;
                    end
                end
                ARB_ADDR: begin
                    if (aw_fire) begin
                        state <= ARB_DATA;
                    end
                end
                ARB_DATA: begin
                    if (w_last_fire) begin
                        state <= ARB_RESP;
                    end
                end
                ARB_RESP: begin
                    if (b_fire) begin
                        grant <= '0;
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    grant <= '0;
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    grant_onehot0: assert property (
        @(posedge aclk) disable iff (!rst_n)
        $onehot0(grant)
    );

    // Owner holds the bus until the response completes
    grant_held: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (state != ARB_IDLE) |=> (state == ARB_IDLE) || $stable(grant)
    );

endmodule

// File: axi_write_interconnect.sv
`timescale 1ns/1ps

module axi_write_interconnect
    import axi_bus_pkg::*;
#(
    parameter int NUM_MASTERS = 3
) (
    input  logic                      aclk,
    input  logic                      rst_n,

    // Master side
    input  axi_aw_t [NUM_MASTERS-1:0] m_aw,
    input  logic    [NUM_MASTERS-1:0] m_awvalid,
    output logic    [NUM_MASTERS-1:0] m_awready,
    input  axi_w_t  [NUM_MASTERS-1:0] m_w,
    input  logic    [NUM_MASTERS-1:0] m_wvalid,
    output logic    [NUM_MASTERS-1:0] m_wready,
    output axi_b_t  [NUM_MASTERS-1:0] m_b,
    output logic    [NUM_MASTERS-1:0] m_bvalid,
    input  logic    [NUM_MASTERS-1:0] m_bready,

    // Slave side
    output axi_aw_t                   s_aw,
    output logic                      s_awvalid,
    input  logic                      s_awready,
    output axi_w_t                    s_w,
    output logic                      s_wvalid,
    input  logic                      s_wready,
    input  axi_b_t                    s_b,
    input  logic                      s_bvalid,
    output logic                      s_bready
);

    logic [NUM_MASTERS-1:0] grant;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Arbitration
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    axi_write_arbiter #(
        .NUM_MASTERS (NUM_MASTERS)
    ) axi_write_arbiter_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .m_awvalid (m_awvalid),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_w       (s_w),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .grant     (grant)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Channel steering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    axi_master_mux_aw #(
        .NUM_MASTERS (NUM_MASTERS)
    ) axi_master_mux_aw_inst (
        .grant     (grant),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready)
    );

    axi_master_mux_w #(
        .NUM_MASTERS (NUM_MASTERS)
    ) axi_master_mux_w_inst (
        .grant    (grant),
        .m_w      (m_w),
        .m_wvalid (m_wvalid),
        .m_wready (m_wready),
        .s_w      (s_w),
        .s_wvalid (s_wvalid),
        .s_wready (s_wready)
    );

    axi_slave_demux_b #(
        .NUM_MASTERS (NUM_MASTERS)
    ) axi_slave_demux_b_inst (
        .grant    (grant),
        .s_b      (s_b),
        .s_bvalid (s_bvalid),
        .s_bready (s_bready),
        .m_b      (m_b),
        .m_bvalid (m_bvalid),
        .m_bready (m_bready)
    );

endmodule

// File: files.f
axi_bus_pkg.sv
axi_write_arbiter.sv
axi_master_mux_aw.sv
axi_master_mux_w.sv
axi_slave_demux_b.sv
axi_write_interconnect.sv
tb_clock_gen.sv
tb_axi_write_interconnect.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_axi_write_interconnect -o tb_sim -f files.f \
    && ./obj_dir/tb_sim | tee sim.log \
    || { echo "Build or run error"; exit 1; }
grep -q "SIMULATION PASSED" sim.log && echo "Run passed" \
    || { echo "Run failed"; exit 1; }

// File: tb_axi_write_interconnect.sv
`timescale 1ns/1ps

module tb_axi_write_interconnect
    import axi_bus_pkg::*;
();

    localparam int NUM_MASTERS = 3;
    localparam int NUM_ENTRIES = 9;
    localparam int FIELDS      = 8;
    localparam int MAX_BEATS   = 4;

    logic                      aclk;
    logic                      rst_n;
    axi_aw_t [NUM_MASTERS-1:0] m_aw;
    logic    [NUM_MASTERS-1:0] m_awvalid;
    logic    [NUM_MASTERS-1:0] m_awready;
    axi_w_t  [NUM_MASTERS-1:0] m_w;
    logic    [NUM_MASTERS-1:0] m_wvalid;
    logic    [NUM_MASTERS-1:0] m_wready;
    axi_b_t  [NUM_MASTERS-1:0] m_b;
    logic    [NUM_MASTERS-1:0] m_bvalid;
    logic    [NUM_MASTERS-1:0] m_bready;
    axi_aw_t                   s_aw;
    logic                      s_awvalid;
    logic                      s_awready;
    axi_w_t                    s_w;
    logic                      s_wvalid;
    logic                      s_wready;
    axi_b_t                    s_b;
    logic                      s_bvalid;
    logic                      s_bready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [31:0]           stim_mem [0:NUM_ENTRIES*FIELDS-1];
    logic [1:0]            ent_master [NUM_ENTRIES];
    logic [ADDR_WIDTH-1:0] ent_addr [NUM_ENTRIES];
    logic [7:0]            ent_len [NUM_ENTRIES];
    logic [DATA_WIDTH-1:0] ent_data [NUM_ENTRIES][MAX_BEATS];
    logic [1:0]            ent_resp [NUM_ENTRIES];
    logic                  ent_seen [NUM_ENTRIES];

    int aw_count [NUM_MASTERS];
    int first_owner [3];
    int aw_total     = 0;
    int b_total      = 0;
    int total_beats  = 0;
    int aw_errors    = 0;
    int w_errors     = 0;
    int b_errors     = 0;
    int other_errors = 0;

    logic                   stim_loaded = 1'b0;
    logic [NUM_MASTERS-1:0] owner_mask  = '0;

    tb_clock_gen #(
        .PERIOD_NS (20)
    ) tb_clock_gen_inst (
        .clk (aclk)
    );

    axi_write_interconnect #(
        .NUM_MASTERS (NUM_MASTERS)
    ) axi_write_interconnect_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .m_w       (m_w),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready),
        .m_b       (m_b),
        .m_bvalid  (m_bvalid),
        .m_bready  (m_bready),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_w       (s_w),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_b       (s_b),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Expected values and compares
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Full-width INCR bursts
    function automatic axi_aw_t expected_aw(input int e);
        axi_aw_t aw;
        aw.addr  = ent_addr[e];
        aw.len   = ent_len[e];
        aw.size  = 3'($clog2(STRB_WIDTH));
        aw.burst = 2'b01;
        return aw;
    endfunction

    function automatic axi_w_t expected_w(input int e, input int b);
        axi_w_t w;
        w.data = ent_data[e][b];
        w.strb = '1;
        w.last = (b == int'(ent_len[e]));
        return w;
    endfunction

    // Position of an entry among its master's entries
    function automatic int entry_rank(input int e);
        int rank;
        rank = 0;
        for (int i = 0; i < e; i++) begin
            if (ent_master[i] == ent_master[e]) begin
                rank++;
            end
        end
        return rank;
    endfunction

    task automatic check_aw(input string name, input axi_aw_t got, input axi_aw_t exp);
        if (got !== exp) begin
            aw_errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_w(input string name, input axi_w_t got, input axi_w_t exp);
        if (got !== exp) begin
            w_errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_b(input string name, input axi_b_t got, input axi_b_t exp);
        if (got !== exp) begin
            b_errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            other_errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_ownership(input string name, input logic [NUM_MASTERS-1:0] seen);
        if ((seen & ~owner_mask) != '0) begin
            other_errors++;
            $display("Fail %s: got 0x%h, owner mask 0x%h", name, seen, owner_mask);
        end
    endtask

    task automatic print_error_counts();
        $display("Errors: aw %0d, w %0d, b %0d, other %0d",
                 aw_errors, w_errors, b_errors, other_errors);
    endtask

    task automatic drive_slot();
        @(posedge aclk);
        #1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Master model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_master(input logic [1:0] m);
        int     d;
        axi_b_t exp;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (ent_master[e] == m) begin
                m_aw[m]      = expected_aw(e);
                m_awvalid[m] = 1'b1;
                do @(negedge aclk); while (!m_awready[m]);
                drive_slot();
                m_awvalid[m] = 1'b0;
                for (int b = 0; b <= int'(ent_len[e]); b++) begin
                    m_w[m]      = expected_w(e, b);
                    m_wvalid[m] = 1'b1;
                    do @(negedge aclk); while (!m_wready[m]);
                    drive_slot();
                end
                m_wvalid[m] = 1'b0;

                // Response with some bready back-pressure
                exp.resp = ent_resp[e];
                do @(negedge aclk); while (!m_bvalid[m]);
                check_b("m_b", m_b[m], exp);
                d = int'($urandom_range(2, 0));
                repeat (d) begin
                    @(negedge aclk);
                    if (!m_bvalid[m]) begin
                        other_errors++;
                        $display("m_bvalid of master %0d dropped before bready", m);
                    end
                    check_b("m_b held", m_b[m], exp);
                end
                drive_slot();
                m_bready[m] = 1'b1;
                @(negedge aclk);
                check_b("m_b held", m_b[m], exp);
                drive_slot();
                m_bready[m] = 1'b0;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slave model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : slave_model
        axi_aw_t    aw_hold;
        axi_w_t     beat;
        int         e;
        int         d;
        int         beats;
        logic [1:0] m;
        s_awready = 1'b0;
        s_wready  = 1'b0;
        s_b       = '0;
        s_bvalid  = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            do @(negedge aclk); while (!s_awvalid);
            aw_hold = s_aw;
            e = -1;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (ent_addr[i] == aw_hold.addr) begin
                    e = i;
                end
            end
            if (e < 0) begin
                other_errors++;
                $display("Address 0x%h on s_aw matches no entry", aw_hold.addr);
            end else begin
                m = ent_master[e];
                check_aw("s_aw", aw_hold, expected_aw(e));
                if (ent_seen[e]) begin
                    other_errors++;
                    $display("Address 0x%h reached the slave twice", aw_hold.addr);
                end
                if (entry_rank(e) != aw_count[m]) begin
                    other_errors++;
                    $display("Master %0d transactions arrived out of file order", m);
                end
                ent_seen[e] = 1'b1;
                aw_count[m]++;
                owner_mask = NUM_MASTERS'(1) << m;
                if (aw_total < 3) begin
                    first_owner[aw_total] = int'(m);
                end
            end
            aw_total++;

            d = int'($urandom_range(3, 0));
            repeat (d) begin
                @(negedge aclk);
                check_aw("s_aw held", s_aw, aw_hold);
            end
            drive_slot();
            s_awready = 1'b1;
            @(negedge aclk);
            check_aw("s_aw held", s_aw, aw_hold);
            drive_slot();
            s_awready = 1'b0;

            beats = int'(aw_hold.len) + 1;
            for (int b = 0; b < beats; b++) begin
                do @(negedge aclk); while (!s_wvalid);
                beat = s_w;
                if (e >= 0) begin
                    check_w("s_w", beat, expected_w(e, b));
                end
                d = int'($urandom_range(3, 0));
                repeat (d) begin
                    @(negedge aclk);
                    if (!s_wvalid) begin
                        other_errors++;
                        $display("s_wvalid dropped before the beat was accepted");
                    end
                    check_w("s_w held", s_w, beat);
                end
                drive_slot();
                s_wready = 1'b1;
                @(negedge aclk);
                check_w("s_w held", s_w, beat);
                drive_slot();
                s_wready = 1'b0;
            end

            d = int'($urandom_range(3, 0));
            repeat (d) drive_slot();
            s_b.resp = (e >= 0) ? ent_resp[e] : 2'b00;
            s_bvalid = 1'b1;
            do @(negedge aclk); while (!s_bready);
            drive_slot();
            s_bvalid   = 1'b0;
            owner_mask = '0;
        end
    end

    // Only the owner may see a ready or a response
    always @(negedge aclk) begin
        if (rst_n) begin
            check_ownership("m_awready", m_awready);
            check_ownership("m_wready", m_wready);
            check_ownership("m_bvalid", m_bvalid);
            // Response handshakes on the master side
            b_total += $countones(m_bvalid & m_bready);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : watchdog
        int limit;
        wait (stim_loaded === 1'b1);
        limit = total_beats * 20 + 1000;
        repeat (limit) @(posedge aclk);
        $display("Timeout after %0d cycles with transactions still open", limit);
        print_error_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h76daefdf));
        rst_n     = 1'b0;
        m_aw      = '0;
        m_awvalid = '0;
        m_w       = '0;
        m_wvalid  = '0;
        m_bready  = '0;

        $readmemh("write_input.txt", stim_mem);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ent_master[i] = stim_mem[i*FIELDS][1:0];
            ent_addr[i]   = stim_mem[i*FIELDS+1];
            ent_len[i]    = stim_mem[i*FIELDS+2][7:0];
            for (int b = 0; b < MAX_BEATS; b++) begin
                ent_data[i][b] = stim_mem[i*FIELDS+3+b];
            end
            ent_resp[i]  = stim_mem[i*FIELDS+7][1:0];
            ent_seen[i]  = 1'b0;
            total_beats += int'(ent_len[i]) + 1;
        end
        for (int i = 0; i < NUM_MASTERS; i++) begin
            aw_count[i] = 0;
        end
        stim_loaded = 1'b1;

        repeat (16) @(posedge aclk);
        if (s_awvalid || s_wvalid || s_bready || (m_awready != '0) ||
            (m_wready != '0) || (m_bvalid != '0)) begin
            other_errors++;
            $display("Handshake outputs are not idle during reset");
        end
        #1;
        rst_n = 1'b1;

        // All masters request together right after reset
        fork
            run_master(2'd0);
            run_master(2'd1);
            run_master(2'd2);
        join

        repeat (4) @(posedge aclk);
        check_count("aw transfers", aw_total, NUM_ENTRIES);
        check_count("b responses", b_total, NUM_ENTRIES);
        for (int i = 0; i < 3; i++) begin
            check_count("first grant order", first_owner[i], i);
        end
        print_error_counts();
        if (aw_errors + w_errors + b_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: write_input.txt
// master addr len data0 data1 data2 data3 resp
// len is the beat count minus one, unused data words are zero
0 00001000 3 a0000000 a0000001 a0000002 a0000003 0
1 00002000 1 b0000000 b0000001 00000000 00000000 2
2 00003000 0 c0000000 00000000 00000000 00000000 0
0 00001100 0 a0000010 00000000 00000000 00000000 3
1 00002100 2 b0000010 b0000011 b0000012 00000000 0
2 00003100 3 c0000010 c0000011 c0000012 c0000013 2
0 00001200 1 a0000020 a0000021 00000000 00000000 0
1 00002200 0 b0000020 00000000 00000000 00000000 3
2 00003200 2 c0000020 c0000021 c0000022 00000000 0
